// File: hdl/lookahead_pkg.sv
package lookahead_pkg;

    // mesh geometry
    localparam int mesh_nx = 4;                      // routers along x
    localparam int mesh_ny = 4;                      // routers along y

    localparam int x_w = $clog2(mesh_nx);            // x coordinate width
    localparam int y_w = $clog2(mesh_ny);            // y coordinate width

    // router ports
    localparam int port_num   = 5;                   // local + four mesh links
    localparam int port_idx_w = $clog2(port_num);    // index of a full port
    localparam int red_idx_w  = $clog2(port_num - 1); // index of a reduced port

    typedef logic [x_w-1:0] coord_x_t;
    typedef logic [y_w-1:0] coord_y_t;

    // highest address on each axis, used for wrap-around
    localparam coord_x_t last_x = coord_x_t'(mesh_nx - 1);
    localparam coord_y_t last_y = coord_y_t'(mesh_ny - 1);

    // port numbering, north is toward smaller y
    typedef enum logic [port_idx_w-1:0] {
        port_local = 3'd0,
        port_east  = 3'd1,
        port_north = 3'd2,
        port_west  = 3'd3,
        port_south = 3'd4
    } port_e;

    typedef logic [port_num-1:0] port_onehot_t;      // indexed by port_e
    typedef logic [port_num-2:0] port_reduced_t;     // one position dropped

endpackage

// File: hdl/lookahead_ifs.sv
`timescale 1ns/100ps

// stage 1 to stage 2: registered request with the widened port
interface route_req_if;
    import lookahead_pkg::*;

    logic         valid;
    coord_x_t     dest_x;
    coord_y_t     dest_y;
    port_onehot_t port;                              // port chosen at this router

    modport src (
        output valid,
        output dest_x,
        output dest_y,
        output port
    );

    modport dst (
        input valid,
        input dest_x,
        input dest_y,
        input port
    );
endinterface

// stage 2 to stage 3: predicted next router and its input port
interface next_hop_if;
    import lookahead_pkg::*;

    logic         valid;
    coord_x_t     dest_x;
    coord_y_t     dest_y;
    coord_x_t     next_x;
    coord_y_t     next_y;
    port_onehot_t recv_port;                         // port the packet arrives on

    modport src (
        output valid,
        output dest_x,
        output dest_y,
        output next_x,
        output next_y,
        output recv_port
    );

    modport dst (
        input valid,
        input dest_x,
        input dest_y,
        input next_x,
        input next_y,
        input recv_port
    );
endinterface

// File: hdl/port_expand_stage.sv
`timescale 1ns/100ps

module port_expand_stage #(
    parameter int sw_loc = 0                         // own port index, 0 is local
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         in_valid,
    input  lookahead_pkg::coord_x_t      dest_x,
    input  lookahead_pkg::coord_y_t      dest_y,
    input  lookahead_pkg::port_reduced_t destport,
    route_req_if.src                     req
);
    import lookahead_pkg::*;

    port_onehot_t port_wide;

    // a switch never routes back to itself, so its own bit was dropped
    // upstream; put a zero back at sw_loc and shift the upper bits up
    for (genvar i = 0; i < port_num; i++) begin : g_insert
        if (i < sw_loc) begin : g_below
            assign port_wide[i] = destport[i];
        end else if (i == sw_loc) begin : g_own
            assign port_wide[i] = 1'b0;
        end else begin : g_above
            assign port_wide[i] = destport[i-1];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req.valid  <= 1'b0;
            req.dest_x <= '0;
            req.dest_y <= '0;
            req.port   <= '0;
        end else begin
            req.valid <= in_valid;
            if (in_valid) begin                      // hold payload between strobes
                req.dest_x <= dest_x;
                req.dest_y <= dest_y;
                req.port   <= port_wide;
            end
        end
    end

endmodule

// File: hdl/next_hop_stage.sv
`timescale 1ns/100ps

module next_hop_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  lookahead_pkg::coord_x_t cur_x,
    input  lookahead_pkg::coord_y_t cur_y,
    route_req_if.dst                req,
    next_hop_if.src                 hop
);
    import lookahead_pkg::*;

    coord_x_t     next_x;
    coord_y_t     next_y;
    port_onehot_t recv_port;

    // address of the neighbour behind the chosen port
    always_comb begin
        next_x = cur_x;                              // local stays here
        next_y = cur_y;
        if (req.port[port_east]) begin
            next_x = (cur_x == last_x) ? '0 : cur_x + 1'b1;
        end else if (req.port[port_north]) begin
            next_y = (cur_y == '0) ? last_y : cur_y - 1'b1;
        end else if (req.port[port_west]) begin
            next_x = (cur_x == '0) ? last_x : cur_x - 1'b1;
        end else if (req.port[port_south]) begin
            next_y = (cur_y == last_y) ? '0 : cur_y + 1'b1;
        end
    end

    // leaving east means arriving on the west side, and so on
    always_comb begin
        recv_port             = '0;
        recv_port[port_local] = req.port[port_local];
        recv_port[port_east]  = req.port[port_west];
        recv_port[port_north] = req.port[port_south];
        recv_port[port_west]  = req.port[port_east];
        recv_port[port_south] = req.port[port_north];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hop.valid     <= 1'b0;
            hop.dest_x    <= '0;
            hop.dest_y    <= '0;
            hop.next_x    <= '0;
            hop.next_y    <= '0;
            hop.recv_port <= '0;
        end else begin
            hop.valid <= req.valid;
            if (req.valid) begin
                hop.dest_x    <= req.dest_x;     // destination rides along
                hop.dest_y    <= req.dest_y;
                hop.next_x    <= next_x;
                hop.next_y    <= next_y;
                hop.recv_port <= recv_port;
            end
        end
    end

endmodule

// File: hdl/lookahead_route_stage.sv
`timescale 1ns/100ps

module lookahead_route_stage (
    input  logic                                clk,
    input  logic                                reset,
    next_hop_if.dst                             hop,
    output logic                                out_valid,
    output lookahead_pkg::port_reduced_t        lkdestport
);
    import lookahead_pkg::*;

    port_onehot_t          route_oh;
    port_e                 route_idx;
    port_e                 recv_idx;
    logic [port_idx_w-1:0] adj_idx;
    logic [red_idx_w-1:0]  out_idx;
    port_reduced_t         lk_next;

    // one-hot port to its index
    function automatic port_e onehot_to_idx(input port_onehot_t oh);
        port_e idx;
        idx = port_local;
        for (int i = 0; i < port_num; i++) begin
            if (oh[i]) begin
                idx = port_e'(i);
            end
        end
        return idx;
    endfunction

    // XY routing as the next router would do it
    always_comb begin
        route_oh = '0;
        if (hop.dest_x > hop.next_x) begin
            route_oh[port_east] = 1'b1;
        end else if (hop.dest_x < hop.next_x) begin
            route_oh[port_west] = 1'b1;
        end else if (hop.dest_y > hop.next_y) begin
            route_oh[port_south] = 1'b1;             // y grows southward
        end else if (hop.dest_y < hop.next_y) begin
            route_oh[port_north] = 1'b1;
        end else begin
            route_oh[port_local] = 1'b1;             // arrived
        end
    end

    assign route_idx = onehot_to_idx(route_oh);
    assign recv_idx  = onehot_to_idx(hop.recv_port);

    // drop the receive port position, ports above it move down one
    assign adj_idx = (recv_idx > route_idx) ? route_idx : route_idx - 1'b1;
    assign out_idx = adj_idx[red_idx_w-1:0];
    assign lk_next = port_reduced_t'(1) << out_idx;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid  <= 1'b0;
            lkdestport <= '0;
        end else begin
            out_valid  <= hop.valid;
            lkdestport <= hop.valid ? lk_next : '0;  // zero when idle
        end
    end

endmodule

// File: hdl/lookahead_routing.sv
`timescale 1ns/100ps

module lookahead_routing #(
    parameter int sw_loc = 0                         // port this unit sits on
) (
    input  logic                         clk,
    input  logic                         reset,
    input  lookahead_pkg::coord_x_t      cur_x,
    input  lookahead_pkg::coord_y_t      cur_y,
    input  logic                         in_valid,
    input  lookahead_pkg::coord_x_t      dest_x,
    input  lookahead_pkg::coord_y_t      dest_y,
    input  lookahead_pkg::port_reduced_t destport,
    output logic                         out_valid,
    output lookahead_pkg::port_reduced_t lkdestport
);

    route_req_if req_bus ();                         // stage 1 to 2
    next_hop_if  hop_bus ();                         // stage 2 to 3

    // request capture and port widening
    port_expand_stage #(
        .sw_loc   (sw_loc)
    ) i_port_expand_stage (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .dest_x   (dest_x),
        .dest_y   (dest_y),
        .destport (destport),
        .req      (req_bus)
    );

    // neighbour address and arrival port
    next_hop_stage i_next_hop_stage (
        .clk   (clk),
        .reset (reset),
        .cur_x (cur_x),
        .cur_y (cur_y),
        .req   (req_bus),
        .hop   (hop_bus)
    );

    // route at the neighbour, reduced to four bits
    lookahead_route_stage i_lookahead_route_stage (
        .clk        (clk),
        .reset      (reset),
        .hop        (hop_bus),
        .out_valid  (out_valid),
        .lkdestport (lkdestport)
    );

endmodule

// File: verification/lookahead_model.svh
`ifndef lookahead_model_svh
`define lookahead_model_svh

// reduced code widened back to five ports, zero at the switch's own slot
function automatic port_onehot_t expand_port(input port_reduced_t red, input int own);
    port_onehot_t wide;
    logic [1:0]   src;
    wide = '0;
    src  = 2'd0;
    for (int p = 0; p < port_num; p++) begin
        if (p != own) begin
            wide[p] = red[src];
            src     = src + 1'b1;
        end
    end
    return wide;
endfunction

// first set port in east, north, west, south order, local if none
function automatic port_e chosen_port(input port_onehot_t wide);
    port_e p;
    p = port_local;
    if (wide[port_east]) p = port_east;
    else if (wide[port_north]) p = port_north;
    else if (wide[port_west]) p = port_west;
    else if (wide[port_south]) p = port_south;
    return p;
endfunction

// neighbour coordinates on a 4x4 array with wrap at the edges
function automatic coord_x_t hop_x(input coord_x_t x, input port_e p);
    int nx;
    nx = int'(x);
    if (p == port_east) nx = (nx + 1) % mesh_nx;
    else if (p == port_west) nx = (nx + mesh_nx - 1) % mesh_nx;
    return coord_x_t'(nx);
endfunction

function automatic coord_y_t hop_y(input coord_y_t y, input port_e p);
    int ny;
    ny = int'(y);
    if (p == port_south) ny = (ny + 1) % mesh_ny;  // south is larger y
    else if (p == port_north) ny = (ny + mesh_ny - 1) % mesh_ny;
    return coord_y_t'(ny);
endfunction

// side of the neighbour the packet comes in on
function automatic port_e arrival_port(input port_e p);
    port_e a;
    case (p)
        port_east:  a = port_west;
        port_west:  a = port_east;
        port_north: a = port_south;
        port_south: a = port_north;
        default:    a = port_local;
    endcase
    return a;
endfunction

// plain XY decision, x first
function automatic port_e xy_port(input coord_x_t dx, input coord_y_t dy,
                                  input coord_x_t nx, input coord_y_t ny);
    port_e r;
    if (dx > nx) r = port_east;
    else if (dx < nx) r = port_west;
    else if (dy > ny) r = port_south;
    else if (dy < ny) r = port_north;
    else r = port_local;
    return r;
endfunction

// 4-bit one-hot with the receive slot taken out
function automatic port_reduced_t reduce_port(input port_e route, input port_e recv);
    int idx;
    idx = int'(route);
    if (int'(recv) <= idx) idx = idx - 1;
    return port_reduced_t'(1) << idx;
endfunction

// full look-ahead answer for one request
function automatic port_reduced_t expected_lookahead(input coord_x_t cx, input coord_y_t cy,
                                                     input coord_x_t dx, input coord_y_t dy,
                                                     input port_reduced_t code);
    port_e go;
    port_e recv;
    go   = chosen_port(expand_port(code, sw_loc));
    recv = arrival_port(go);
    return reduce_port(xy_port(dx, dy, hop_x(cx, go), hop_y(cy, go)), recv);
endfunction

`endif

// File: verification/lookahead_routing_tb.sv
`timescale 1ns/100ps

module lookahead_routing_tb;
    import lookahead_pkg::*;

    localparam int sw_loc     = 0;                   // unit sits on the local port
    localparam int fifo_depth = 512;
    // 5 reset + 3 quiet + ~30 directed + 5 moves x 4 drain + 256 random
    // + ~16 idle + 2 moves x 4 + final drain is about 345 cycles
    localparam int cycle_limit = 400;

    logic          clk = 1'b0;
    logic          reset;
    coord_x_t      cur_x;
    coord_y_t      cur_y;
    logic          in_valid;
    coord_x_t      dest_x;
    coord_y_t      dest_y;
    port_reduced_t destport;
    logic          out_valid;
    port_reduced_t lkdestport;

    integer seed = 32'h3c6d_fbc7;
    int     cyc  = 0;

    // expected results in request order
    port_reduced_t exp_lk  [fifo_depth];
    int            exp_due [fifo_depth];                 // cycle out_valid is sampled high
    logic [8:0]    wr_ptr = '0;
    logic [8:0]    rd_ptr = '0;

    `include "lookahead_model.svh"

    always #50 clk = ~clk;

    lookahead_routing #(
        .sw_loc     (sw_loc)
    ) i_lookahead_routing (
        .clk        (clk),
        .reset      (reset),
        .cur_x      (cur_x),
        .cur_y      (cur_y),
        .in_valid   (in_valid),
        .dest_x     (dest_x),
        .dest_y     (dest_y),
        .destport   (destport),
        .out_valid  (out_valid),
        .lkdestport (lkdestport)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= cycle_limit) fail_run($sformatf("timeout after %0d cycles", cyc));
    end

    always @(posedge clk) begin
        if (out_valid) rd_ptr <= rd_ptr + 1'b1;      // head moves on every result
    end

    idle_zero_check: assert property (@(posedge clk) !out_valid |-> lkdestport == '0)
        else fail_run($sformatf("CHECK FAILED lkdestport expected 0x0 actual 0x%h",
                                $sampled(lkdestport)));

    spurious_check: assert property (@(posedge clk) out_valid |-> rd_ptr != wr_ptr)
        else fail_run("out_valid went high with no request outstanding");

    on_time_check: assert property (@(posedge clk)
        out_valid && (rd_ptr != wr_ptr) |-> cyc == exp_due[rd_ptr])
        else fail_run($sformatf("out_valid for request %0d came at cycle %0d, not %0d",
                                $sampled(rd_ptr), $sampled(cyc), exp_due[$sampled(rd_ptr)]));

    missing_check: assert property (@(posedge clk)
        !out_valid && (rd_ptr != wr_ptr) |-> cyc != exp_due[rd_ptr])
        else fail_run($sformatf("out_valid for request %0d missing at cycle %0d",
                                $sampled(rd_ptr), $sampled(cyc)));

    value_check: assert property (@(posedge clk)
        out_valid && (rd_ptr != wr_ptr) |-> lkdestport == exp_lk[rd_ptr])
        else fail_run($sformatf("CHECK FAILED lkdestport expected 0x%h actual 0x%h",
                                exp_lk[$sampled(rd_ptr)], $sampled(lkdestport)));

    // reduced code that selects port p at this switch
    function automatic port_reduced_t code_for(input port_e p);
        int slot;
        slot = int'(p);
        if (slot > sw_loc) slot = slot - 1;
        return port_reduced_t'(1) << slot;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #5;
            in_valid = 1'b0;
        end
    endtask

    task automatic send_request(input coord_x_t dx, input coord_y_t dy,
                                input port_reduced_t code);
        @(posedge clk);
        #5;
        in_valid = 1'b1;
        dest_x   = dx;
        dest_y   = dy;
        destport = code;
        exp_lk[wr_ptr]  = expected_lookahead(cur_x, cur_y, dx, dy, code);
        exp_due[wr_ptr] = cyc + 3;                   // capture, two stages, sample
        wr_ptr = wr_ptr + 1'b1;
    endtask

    task automatic wait_drain();
        idle_cycles(1);
        while (rd_ptr != wr_ptr) idle_cycles(1);
    endtask

    // address only changes with the pipeline empty
    task automatic place_router(input coord_x_t x, input coord_y_t y);
        wait_drain();
        cur_x = x;
        cur_y = y;
    endtask

    task automatic random_block(input int count);
        int pick;
        place_router(coord_x_t'($random(seed)), coord_y_t'($random(seed)));
        for (int i = 0; i < count; i++) begin
            if (($random(seed) & 15) == 0) idle_cycles(1);  // occasional gap
            pick = $random(seed) & 3;
            send_request(coord_x_t'($random(seed)), coord_y_t'($random(seed)),
                         port_reduced_t'(1) << pick);
        end
    endtask

    initial begin
        reset    = 1'b1;
        cur_x    = '0;
        cur_y    = '0;
        in_valid = 1'b0;
        dest_x   = '0;
        dest_y   = '0;
        destport = '0;
        repeat (5) @(posedge clk);
        #5;
        reset = 1'b0;
        idle_cycles(3);                              // quiet after reset

        place_router(2'd3, 2'd3);                    // corner where east and south wrap
        send_request(2'd1, 2'd3, code_for(port_east));
        send_request(2'd3, 2'd1, code_for(port_south));
        send_request(2'd0, 2'd3, code_for(port_east));
        send_request(2'd3, 2'd0, code_for(port_south));
        send_request(2'd2, 2'd2, code_for(port_west));
        send_request(2'd3, 2'd2, code_for(port_north));

        place_router(2'd0, 2'd0);                    // corner where west and north wrap
        send_request(2'd2, 2'd0, code_for(port_west));
        send_request(2'd0, 2'd2, code_for(port_north));
        send_request(2'd3, 2'd0, code_for(port_west));
        send_request(2'd0, 2'd3, code_for(port_north));
        send_request(2'd1, 2'd0, code_for(port_east));
        send_request(2'd0, 2'd1, code_for(port_south));
        send_request(2'd3, 2'd3, code_for(port_east));

        place_router(2'd3, 2'd0);
        send_request(2'd0, 2'd0, code_for(port_east));
        send_request(2'd3, 2'd3, code_for(port_north));
        send_request(2'd2, 2'd1, code_for(port_east));
        send_request(2'd1, 2'd3, code_for(port_north));

        place_router(2'd0, 2'd3);
        send_request(2'd3, 2'd3, code_for(port_west));
        send_request(2'd0, 2'd0, code_for(port_south));
        send_request(2'd1, 2'd2, code_for(port_west));
        send_request(2'd2, 2'd0, code_for(port_south));

        place_router(2'd1, 2'd2);                    // inner router with back to back requests
        send_request(2'd2, 2'd2, '0);                // no port set so it arrives on local
        send_request(2'd1, 2'd0, '0);
        send_request(2'd0, 2'd3, '0);
        send_request(2'd3, 2'd2, code_for(port_east));
        send_request(2'd1, 2'd0, code_for(port_north));
        send_request(2'd0, 2'd1, code_for(port_west));
        send_request(2'd1, 2'd3, code_for(port_south));
        send_request(2'd2, 2'd2, code_for(port_east));
        send_request(2'd1, 2'd1, code_for(port_north));

        random_block(128);
        random_block(128);

        wait_drain();
        idle_cycles(3);                              // no stray result after the last one
        $display("Test passed");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+verification
hdl/lookahead_pkg.sv
hdl/lookahead_ifs.sv
hdl/port_expand_stage.sv
hdl/next_hop_stage.sv
hdl/lookahead_route_stage.sv
hdl/lookahead_routing.sv
verification/lookahead_routing_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f filelist.f \
		--top-module lookahead_routing_tb -Mdir obj_dir -o lookahead_sim
	./obj_dir/lookahead_sim | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@grep -q "Test passed" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
